// File: flist.f
hw/core_types_pkg.sv
hw/lsu_pkg.sv
hw/lsu_mhq.sv
hw/lsu_lq.sv
hw/lsu_lq_top.sv
testbench/tb_clkgen.sv
testbench/tb_lsu_lq.sv

// File: hw/core_types_pkg.sv
// Core-wide address and ROB tag widths and their types
package core_types_pkg;

    // Byte addresses are 32 bits wide across the whole core
    localparam int ADDR_WIDTH = 32;

    // ROB tags identify an op and also give its age
    localparam int ROB_TAG_WIDTH = 6;

    // A byte address as seen by the LSU and the caches
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // A ROB tag, compared for equality when an op retires
    typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;

endpackage

// File: hw/lsu_lq.sv
// Load queue with allocation, retire, miss bookkeeping, replay selection and store overlap check
`timescale 1ns/1ps

module lsu_lq
    import core_types_pkg::*, lsu_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,

    input  logic      i_flush,
    output logic      o_full,

    // New loads from issue
    input  logic      i_alloc_en,
    input  rob_tag_t  i_alloc_tag,
    input  addr_t     i_alloc_addr,
    input  lsu_func_t i_alloc_lsu_func,

    // Loads sent back to the execute stage
    input  logic      i_replay_stall,
    output logic      o_replay_en,
    output rob_tag_t  o_replay_tag,
    output addr_t     o_replay_addr,
    output lsu_func_t o_replay_lsu_func,

    // Miss report for the load allocated or replayed one cycle earlier
    input  logic      i_update_en,
    input  logic      i_update_retry,
    input  mhq_tag_t  i_update_mhq_tag,

    // Fill broadcast from the MHQ
    input  logic      i_mhq_fill,
    input  mhq_tag_t  i_mhq_fill_tag,

    // Retiring store from the store queue
    input  logic      i_sq_retire_en,
    input  addr_t     i_sq_retire_addr,
    input  lsu_func_t i_sq_retire_lsu_func,

    // Retiring load from the ROB
    input  logic      i_rob_retire_en,
    input  rob_tag_t  i_rob_retire_tag,
    output logic      o_rob_retire_misspeculated
);

    // Per-slot control state, cleared by reset and by flush
    logic [LQ_DEPTH-1:0]     slot_valid;
    logic [LQ_DEPTH-1:0]     slot_needs_replay;
    logic [LQ_DEPTH-1:0]     slot_replay_rdy;
    logic [LQ_DEPTH-1:0]     slot_misspec;

    // Per-slot payload, written on allocate or on a miss report
    addr_t                   slot_addr    [LQ_DEPTH];
    rob_tag_t                slot_tag     [LQ_DEPTH];
    lsu_func_t               slot_func    [LQ_DEPTH];
    logic [LQ_DEPTH-1:0]     slot_retry;
    mhq_tag_t                slot_mhq_tag [LQ_DEPTH];

    logic [LQ_DEPTH-1:0]     alloc_sel;
    logic [LQ_DEPTH-1:0]     replay_sel;
    logic [LQ_DEPTH-1:0]     retire_sel;
    logic [LQ_DEPTH-1:0]     update_sel;
    logic [LQ_DEPTH-1:0]     update_sel_q;
    logic [LQ_DEPTH-1:0]     fill_wake;
    logic [LQ_DEPTH-1:0]     overlap_vec;
    logic [LQ_IDX_WIDTH-1:0] replay_idx;
    logic                    replay_stall;
    logic                    update_fill_rdy;
    addr_t                   sq_size;

    // Keeps only the lowest set bit of a request vector
    function automatic logic [LQ_DEPTH-1:0] pick_lowest(input logic [LQ_DEPTH-1:0] req);
        return req & ~(req - 1'b1);
    endfunction

    // Turns a one-hot slot vector into a slot index
    function automatic logic [LQ_IDX_WIDTH-1:0] onehot_to_idx(input logic [LQ_DEPTH-1:0] sel);
        logic [LQ_IDX_WIDTH-1:0] idx;
        idx = '0;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (sel[i]) begin
                idx = i[LQ_IDX_WIDTH-1:0];
            end
        end
        return idx;
    endfunction

    // Full only when every slot holds a load, so it trails the last allocate by a cycle
    assign o_full    = &slot_valid;
    assign alloc_sel = (i_alloc_en && !o_full) ? pick_lowest(~slot_valid) : '0;

    // A fill or a retiring store owns the execute stage this cycle, so no replay goes out
    assign replay_stall = i_replay_stall | i_mhq_fill | i_sq_retire_en;
    assign replay_sel   = replay_stall ? '0 : pick_lowest(slot_valid & slot_replay_rdy);
    assign replay_idx   = onehot_to_idx(replay_sel);

    assign o_replay_en       = |replay_sel;
    assign o_replay_tag      = slot_tag[replay_idx];
    assign o_replay_addr     = slot_addr[replay_idx];
    assign o_replay_lsu_func = slot_func[replay_idx];

    // The miss report applies to whichever slot went to execute last cycle
    assign update_sel = i_update_en ? update_sel_q : '0;

    // A load can miss on a line that is being filled right now
    // In that case it is ready at once, and for a retry miss any fill will do
    assign update_fill_rdy = i_mhq_fill & (i_update_retry | (i_update_mhq_tag == i_mhq_fill_tag));

    // Bytes written by the retiring store
    always_comb begin
        case (i_sq_retire_lsu_func)
            LSU_FUNC_SB: sq_size = addr_t'(1);
            LSU_FUNC_SH: sq_size = addr_t'(2);
            LSU_FUNC_SW: sq_size = addr_t'(4);
            default:     sq_size = '0;
        endcase
    end

    always_comb begin
        for (int i = 0; i < LQ_DEPTH; i++) begin
            // Tags are unique among valid slots, so at most one bit is set
            retire_sel[i] = i_rob_retire_en & slot_valid[i] & (slot_tag[i] == i_rob_retire_tag);

            // Retry loads wake on any fill, the rest only on their own line
            fill_wake[i]  = i_mhq_fill & slot_valid[i] & slot_needs_replay[i]
                          & (slot_retry[i] | (slot_mhq_tag[i] == i_mhq_fill_tag));

            // The load start lies in the store range when its offset from the store is small
            // A waiting load has not read memory yet, so the store cannot hurt it
            overlap_vec[i] = i_sq_retire_en & slot_valid[i] & ~slot_needs_replay[i]
                           & ((slot_addr[i] - i_sq_retire_addr) < sq_size);
        end
    end

    assign o_rob_retire_misspeculated = |(retire_sel & slot_misspec);

    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            slot_valid        <= '0;
            slot_needs_replay <= '0;
            slot_replay_rdy   <= '0;
            slot_misspec      <= '0;
            update_sel_q      <= '0;
        end else begin
            for (int i = 0; i < LQ_DEPTH; i++) begin
                // Allocation only picks free slots and retire only valid ones
                if (alloc_sel[i]) begin
                    slot_valid[i] <= 1'b1;
                end else if (retire_sel[i]) begin
                    slot_valid[i] <= 1'b0;
                end

                // A presented load leaves the replay path until it misses again
                if (alloc_sel[i] || replay_sel[i]) begin
                    slot_needs_replay[i] <= 1'b0;
                    slot_replay_rdy[i]   <= 1'b0;
                end else if (update_sel[i]) begin
                    slot_needs_replay[i] <= 1'b1;
                    slot_replay_rdy[i]   <= update_fill_rdy;
                end else if (fill_wake[i]) begin
                    slot_replay_rdy[i]   <= 1'b1;
                end

                // Once marked, a load stays marked until its slot is reused
                if (alloc_sel[i]) begin
                    slot_misspec[i] <= 1'b0;
                end else if (overlap_vec[i]) begin
                    slot_misspec[i] <= 1'b1;
                end
            end

            // Replay wins over allocate when both go to execute in one cycle
            update_sel_q <= (|replay_sel) ? replay_sel : alloc_sel;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (alloc_sel[i]) begin
                slot_addr[i] <= i_alloc_addr;
                slot_tag[i]  <= i_alloc_tag;
                slot_func[i] <= i_alloc_lsu_func;
            end
            // The MHQ answer for this miss, used later to match fills
            if (update_sel[i]) begin
                slot_retry[i]   <= i_update_retry;
                slot_mhq_tag[i] <= i_update_mhq_tag;
            end
        end
    end

    // Issue watches o_full and must hold back new loads while it is high
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_alloc_en |-> !o_full
    ) else $error("load allocated while the load queue is full");

    // The ROB hands out unique tags, so a retire hits one slot or none
    a_retire_tag_unique: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_rob_retire_en |-> $onehot0(retire_sel)
    ) else $error("retiring tag matches more than one load queue slot");

endmodule

// File: hw/lsu_lq_top.sv
// Top level joining the load queue and the MHQ
`timescale 1ns/1ps

module lsu_lq_top
    import core_types_pkg::*, lsu_pkg::*;
(
    input  logic      clk,
    input  logic      n_rst,
    input  logic      i_flush,

    // Issue
    input  logic      i_alloc_en,
    input  rob_tag_t  i_alloc_tag,
    input  addr_t     i_alloc_addr,
    input  lsu_func_t i_alloc_lsu_func,
    output logic      o_full,

    // Execute result and stall
    input  logic      i_ex_miss_en,
    input  addr_t     i_ex_miss_addr,
    input  logic      i_replay_stall,

    // Memory
    input  logic      i_mem_fill_en,
    input  mhq_tag_t  i_mem_fill_tag,

    // Store queue
    input  logic      i_sq_retire_en,
    input  addr_t     i_sq_retire_addr,
    input  lsu_func_t i_sq_retire_lsu_func,

    // ROB
    input  logic      i_rob_retire_en,
    input  rob_tag_t  i_rob_retire_tag,
    output logic      o_rob_retire_misspeculated,

    // Replay toward execute
    output logic      o_replay_en,
    output rob_tag_t  o_replay_tag,
    output addr_t     o_replay_addr,
    output lsu_func_t o_replay_lsu_func
);

    // MHQ answer to the current miss and its fill broadcast
    mhq_tag_t mhq_miss_tag;
    logic     mhq_miss_retry;
    logic     mhq_fill;
    mhq_tag_t mhq_fill_tag;

    lsu_lq u_lsu_lq (
        .clk                        (clk),
        .n_rst                      (n_rst),
        .i_flush                    (i_flush),
        .o_full                     (o_full),
        .i_alloc_en                 (i_alloc_en),
        .i_alloc_tag                (i_alloc_tag),
        .i_alloc_addr               (i_alloc_addr),
        .i_alloc_lsu_func           (i_alloc_lsu_func),
        .i_replay_stall             (i_replay_stall),
        .o_replay_en                (o_replay_en),
        .o_replay_tag               (o_replay_tag),
        .o_replay_addr              (o_replay_addr),
        .o_replay_lsu_func          (o_replay_lsu_func),
        .i_update_en                (i_ex_miss_en),
        .i_update_retry             (mhq_miss_retry),
        .i_update_mhq_tag           (mhq_miss_tag),
        .i_mhq_fill                 (mhq_fill),
        .i_mhq_fill_tag             (mhq_fill_tag),
        .i_sq_retire_en             (i_sq_retire_en),
        .i_sq_retire_addr           (i_sq_retire_addr),
        .i_sq_retire_lsu_func       (i_sq_retire_lsu_func),
        .i_rob_retire_en            (i_rob_retire_en),
        .i_rob_retire_tag           (i_rob_retire_tag),
        .o_rob_retire_misspeculated (o_rob_retire_misspeculated)
    );

    lsu_mhq u_lsu_mhq (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_miss_en      (i_ex_miss_en),
        .i_miss_addr    (i_ex_miss_addr),
        .o_miss_tag     (mhq_miss_tag),
        .o_miss_retry   (mhq_miss_retry),
        .i_mem_fill_en  (i_mem_fill_en),
        .i_mem_fill_tag (i_mem_fill_tag),
        .o_fill         (mhq_fill),
        .o_fill_tag     (mhq_fill_tag)
    );

endmodule

// File: hw/lsu_mhq.sv
// Miss-handling queue that allocates or merges cache line tags and broadcasts fills
`timescale 1ns/1ps

module lsu_mhq
    import core_types_pkg::*, lsu_pkg::*;
(
    input  logic     clk,
    input  logic     n_rst,

    // Miss request from the execute stage
    input  logic     i_miss_en,
    input  addr_t    i_miss_addr,
    output mhq_tag_t o_miss_tag,
    output logic     o_miss_retry,

    // Line fill returned by memory
    input  logic     i_mem_fill_en,
    input  mhq_tag_t i_mem_fill_tag,

    // Fill broadcast to the load queue
    output logic     o_fill,
    output mhq_tag_t o_fill_tag
);

    logic [MHQ_DEPTH-1:0]                  entry_valid;
    logic [ADDR_WIDTH-1:LINE_OFFSET_WIDTH] entry_line [MHQ_DEPTH];

    logic [ADDR_WIDTH-1:LINE_OFFSET_WIDTH] miss_line;
    logic [MHQ_DEPTH-1:0]                  match_vec;
    logic [MHQ_DEPTH-1:0]                  free_vec;
    logic [MHQ_DEPTH-1:0]                  free_sel;
    logic [MHQ_DEPTH-1:0]                  alloc_sel;
    logic [MHQ_DEPTH-1:0]                  fill_sel;
    logic                                  merge_hit;

    // Turns a one-hot entry vector into its tag
    function automatic mhq_tag_t onehot_to_tag(input logic [MHQ_DEPTH-1:0] sel);
        mhq_tag_t tag;
        tag = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (sel[i]) begin
                tag = i[MHQ_TAG_WIDTH-1:0];
            end
        end
        return tag;
    endfunction

    // Misses are tracked per line, not per byte
    assign miss_line = i_miss_addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH];

    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            match_vec[i] = entry_valid[i] & (entry_line[i] == miss_line);
        end
    end

    assign merge_hit = |match_vec;
    assign free_vec  = ~entry_valid;
    assign free_sel  = free_vec & ~(free_vec - 1'b1);

    // A line already in flight is shared, otherwise the lowest free entry is named
    assign o_miss_tag   = merge_hit ? onehot_to_tag(match_vec) : onehot_to_tag(free_sel);
    assign o_miss_retry = ~merge_hit & ~(|free_vec);

    assign alloc_sel = (i_miss_en && !merge_hit) ? free_sel : '0;

    // Fills for entries not in flight are dropped
    assign o_fill     = i_mem_fill_en & entry_valid[i_mem_fill_tag];
    assign o_fill_tag = i_mem_fill_tag;
    assign fill_sel   = o_fill ? (MHQ_DEPTH'(1) << i_mem_fill_tag) : '0;

    // Allocate only picks free entries and a fill only frees a valid one
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            entry_valid <= '0;
        end else begin
            entry_valid <= (entry_valid | alloc_sel) & ~fill_sel;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (alloc_sel[i]) begin
                entry_line[i] <= miss_line;
            end
        end
    end

    // Memory only returns lines that were requested and are still outstanding
    a_fill_names_valid: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_mem_fill_en |-> entry_valid[i_mem_fill_tag]
    ) else $error("memory fill names an MHQ entry that is not in flight");

endmodule

// File: hw/lsu_pkg.sv
// LSU memory-op encoding, queue depths, index widths and cache line size
package lsu_pkg;

    // Memory ops handled by the LSU
    // Loads come first and stores last, so the store ops share the top codes
    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'b000,
        LSU_FUNC_LH  = 3'b001,
        LSU_FUNC_LW  = 3'b010,
        LSU_FUNC_LBU = 3'b011,
        LSU_FUNC_LHU = 3'b100,
        LSU_FUNC_SB  = 3'b101,
        LSU_FUNC_SH  = 3'b110,
        LSU_FUNC_SW  = 3'b111
    } lsu_func_t;

    // Load queue size and the width of a slot index
    localparam int LQ_DEPTH     = 8;
    localparam int LQ_IDX_WIDTH = 3;

    // Miss-handling queue size and the width of its tag
    localparam int MHQ_DEPTH     = 4;
    localparam int MHQ_TAG_WIDTH = 2;

    // Names one MHQ entry, i.e. one outstanding cache line
    typedef logic [MHQ_TAG_WIDTH-1:0] mhq_tag_t;

    // A cache line holds 16 bytes
    // The line address is the byte address without these low bits
    localparam int LINE_OFFSET_WIDTH = 4;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the load queue simulation with Verilator
# The exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lsu_lq -f flist.f -o sim_lsu_lq
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_lsu_lq
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0

// File: testbench/tb_clkgen.sv
// Clock and reset generator for the load queue testbench
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk,
    output logic o_n_rst
);

    // Free-running clock with a 10 ns period
    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // Reset stays low for the first five rising edges
    initial begin
        o_n_rst = 1'b0;
        repeat (5) @(posedge o_clk);
        o_n_rst <= 1'b1;
    end

endmodule

// File: testbench/tb_lsu_lq.sv
// Testbench for the load queue top level with overlap reference, MHQ model and scenarios
`timescale 1ns/1ps

module tb_lsu_lq
    import core_types_pkg::*, lsu_pkg::*;
();

    logic      clk;
    logic      n_rst;
    logic      i_flush;
    logic      i_alloc_en;
    rob_tag_t  i_alloc_tag;
    addr_t     i_alloc_addr;
    lsu_func_t i_alloc_lsu_func;
    logic      o_full;
    logic      i_ex_miss_en;
    addr_t     i_ex_miss_addr;
    logic      i_replay_stall;
    logic      i_mem_fill_en;
    mhq_tag_t  i_mem_fill_tag;
    logic      i_sq_retire_en;
    addr_t     i_sq_retire_addr;
    lsu_func_t i_sq_retire_lsu_func;
    logic      i_rob_retire_en;
    rob_tag_t  i_rob_retire_tag;
    logic      o_rob_retire_misspeculated;
    logic      o_replay_en;
    rob_tag_t  o_replay_tag;
    addr_t     o_replay_addr;
    lsu_func_t o_replay_lsu_func;

    // Model of the MHQ entries in flight and the line each one holds
    logic [MHQ_DEPTH-1:0]                  mdl_valid;
    logic [ADDR_WIDTH-1:LINE_OFFSET_WIDTH] mdl_line [MHQ_DEPTH];

    integer    seed;
    addr_t     ld_addr [LQ_DEPTH];
    logic      ld_mis  [LQ_DEPTH];
    addr_t     st_addr;
    lsu_func_t st_func;

    tb_clkgen u_clkgen (
        .o_clk   (clk),
        .o_n_rst (n_rst)
    );

    lsu_lq_top u_dut (.*);

    // True when the load start lies inside the bytes written by the store
    function automatic logic ref_overlap(input addr_t load_addr, input addr_t store_addr,
                                         input lsu_func_t func);
        logic [ADDR_WIDTH:0] lo;
        logic [ADDR_WIDTH:0] hi;
        lo = {1'b0, store_addr};
        case (func)
            LSU_FUNC_SB: hi = lo + 33'd1;
            LSU_FUNC_SH: hi = lo + 33'd2;
            LSU_FUNC_SW: hi = lo + 33'd4;
            default:     hi = lo;
        endcase
        return ({1'b0, load_addr} >= lo) && ({1'b0, load_addr} < hi);
    endfunction

    // The MHQ names a matching line first, else the lowest free entry, else -1 for a retry
    function automatic int model_tag(input addr_t addr);
        int tag;
        tag = -1;
        for (int i = MHQ_DEPTH - 1; i >= 0; i--) begin
            if (!mdl_valid[i]) begin
                tag = i;
            end
        end
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (mdl_valid[i] && mdl_line[i] == addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH]) begin
                tag = i;
            end
        end
        return tag;
    endfunction

    task automatic abort_run(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] time %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
            abort_run("value mismatch");
        end
    endtask

    // Allocate one load, then report a hit or a miss in the following cycle
    task automatic alloc_load(input rob_tag_t tag, input addr_t addr, input lsu_func_t func,
                              input logic miss);
        int t;
        @(posedge clk);
        i_alloc_en       <= 1'b1;
        i_alloc_tag      <= tag;
        i_alloc_addr     <= addr;
        i_alloc_lsu_func <= func;
        @(posedge clk);
        i_alloc_en     <= 1'b0;
        i_ex_miss_en   <= miss;
        i_ex_miss_addr <= addr;
        // A retry miss takes no entry
        t = model_tag(addr);
        if (miss && t >= 0) begin
            mdl_valid[t] = 1'b1;
            mdl_line[t]  = addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH];
        end
        @(posedge clk);
        i_ex_miss_en <= 1'b0;
    endtask

    // Memory returns the line, using the tag that the model says the MHQ gave it
    task automatic fill_line(input addr_t addr);
        int t;
        t = model_tag(addr);
        if (t < 0 || !mdl_valid[t]) begin
            abort_run("no MHQ entry is in flight for the line to be filled");
        end
        @(posedge clk);
        i_mem_fill_en  <= 1'b1;
        i_mem_fill_tag <= mhq_tag_t'(t);
        mdl_valid[t] = 1'b0;
        @(posedge clk);
        i_mem_fill_en <= 1'b0;
    endtask

    task automatic retire_store(input addr_t addr, input lsu_func_t func);
        @(posedge clk);
        i_sq_retire_en       <= 1'b1;
        i_sq_retire_addr     <= addr;
        i_sq_retire_lsu_func <= func;
        @(posedge clk);
        i_sq_retire_en <= 1'b0;
    endtask

    // The mis-speculation flag is combinational, so it is checked mid-cycle
    task automatic retire_load(input rob_tag_t tag, input logic exp_mis);
        @(posedge clk);
        i_rob_retire_en  <= 1'b1;
        i_rob_retire_tag <= tag;
        @(negedge clk);
        check_val("o_rob_retire_misspeculated", exp_mis, o_rob_retire_misspeculated);
        @(posedge clk);
        i_rob_retire_en <= 1'b0;
    endtask

    task automatic flush_queue();
        @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
    endtask

    task automatic wait_replay(input rob_tag_t tag, input addr_t addr, input lsu_func_t func);
        int n;
        n = 0;
        @(negedge clk);
        while (!o_replay_en && n < 20) begin
            n++;
            @(negedge clk);
        end
        if (!o_replay_en) begin
            abort_run("timed out waiting for a load replay");
        end
        check_val("o_replay_tag", tag, o_replay_tag);
        check_val("o_replay_addr", addr, o_replay_addr);
        check_val("o_replay_lsu_func", func, o_replay_lsu_func);
    endtask

    task automatic expect_no_replay(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_val("o_replay_en", 1'b0, o_replay_en);
        end
    endtask

    initial begin
        int n;
        seed      = 32'h7328c340;
        mdl_valid = '0;
        i_flush              <= 1'b0;
        i_alloc_en           <= 1'b0;
        i_alloc_tag          <= '0;
        i_alloc_addr         <= '0;
        i_alloc_lsu_func     <= LSU_FUNC_LW;
        i_ex_miss_en         <= 1'b0;
        i_ex_miss_addr       <= '0;
        i_replay_stall       <= 1'b0;
        i_mem_fill_en        <= 1'b0;
        i_mem_fill_tag       <= '0;
        i_sq_retire_en       <= 1'b0;
        i_sq_retire_addr     <= '0;
        i_sq_retire_lsu_func <= LSU_FUNC_SW;
        i_rob_retire_en      <= 1'b0;
        i_rob_retire_tag     <= '0;

        n = 0;
        while (n_rst !== 1'b1 && n < 20) begin
            n++;
            @(negedge clk);
        end
        if (n_rst !== 1'b1) begin
            abort_run("reset was never released");
        end
        check_val("o_full", 1'b0, o_full);
        check_val("o_replay_en", 1'b0, o_replay_en);
        check_val("o_rob_retire_misspeculated", 1'b0, o_rob_retire_misspeculated);

        // Fill every slot with hits, then free one by its tag
        for (int i = 0; i < LQ_DEPTH; i++) begin
            alloc_load(rob_tag_t'(i), addr_t'($random(seed)), LSU_FUNC_LW, 1'b0);
        end
        @(negedge clk);
        check_val("o_full", 1'b1, o_full);
        retire_load(rob_tag_t'(3), 1'b0);
        @(negedge clk);
        check_val("o_full", 1'b0, o_full);
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (i != 3) begin
                retire_load(rob_tag_t'(i), 1'b0);
            end
        end

        // Loads sit in a 64-byte window so random stores often land on them
        for (int i = 0; i < LQ_DEPTH; i++) begin
            ld_addr[i] = 32'h1000 + (addr_t'($random(seed)) & 32'h3f);
            ld_mis[i]  = 1'b0;
            alloc_load(rob_tag_t'(8 + i), ld_addr[i], lsu_func_t'(i % 5), 1'b0);
        end
        for (int s = 0; s < 6; s++) begin
            st_addr = (s == 0) ? ld_addr[0] : 32'h1000 + (addr_t'($random(seed)) & 32'h3f);
            st_func = lsu_func_t'(5 + s % 3);
            for (int i = 0; i < LQ_DEPTH; i++) begin
                ld_mis[i] = ld_mis[i] | ref_overlap(ld_addr[i], st_addr, st_func);
            end
            retire_store(st_addr, st_func);
        end
        for (int i = 0; i < LQ_DEPTH; i++) begin
            retire_load(rob_tag_t'(8 + i), ld_mis[i]);
        end

        // Two lines miss; only the second one is filled first
        alloc_load(6'd20, 32'h2004, LSU_FUNC_LW, 1'b1);
        alloc_load(6'd21, 32'h3008, LSU_FUNC_LH, 1'b1);
        expect_no_replay(3);
        fill_line(32'h3008);
        wait_replay(6'd21, 32'h3008, LSU_FUNC_LH);
        expect_no_replay(3);
        fill_line(32'h2004);
        wait_replay(6'd20, 32'h2004, LSU_FUNC_LW);
        retire_load(6'd20, 1'b0);
        retire_load(6'd21, 1'b0);

        // Slots 0 and 1 share a line, slots 2 to 4 use up the MHQ and slot 5 gets retry
        alloc_load(6'd22, 32'h4000, LSU_FUNC_LW, 1'b1);
        alloc_load(6'd23, 32'h4008, LSU_FUNC_LBU, 1'b1);
        alloc_load(6'd24, 32'h5000, LSU_FUNC_LW, 1'b1);
        alloc_load(6'd25, 32'h6000, LSU_FUNC_LH, 1'b1);
        alloc_load(6'd26, 32'h7000, LSU_FUNC_LB, 1'b1);
        alloc_load(6'd27, 32'h8000, LSU_FUNC_LHU, 1'b1);
        fill_line(32'h5000);
        wait_replay(6'd24, 32'h5000, LSU_FUNC_LW);
        wait_replay(6'd27, 32'h8000, LSU_FUNC_LHU);
        fill_line(32'h4000);
        wait_replay(6'd22, 32'h4000, LSU_FUNC_LW);
        wait_replay(6'd23, 32'h4008, LSU_FUNC_LBU);
        fill_line(32'h6000);
        wait_replay(6'd25, 32'h6000, LSU_FUNC_LH);
        fill_line(32'h7000);
        wait_replay(6'd26, 32'h7000, LSU_FUNC_LB);
        for (int i = 22; i < 28; i++) begin
            retire_load(rob_tag_t'(i), 1'b0);
        end

        // A ready load holds back while the execute stage is busy
        alloc_load(6'd30, 32'h9000, LSU_FUNC_LW, 1'b1);
        @(posedge clk);
        i_replay_stall <= 1'b1;
        fill_line(32'h9000);
        expect_no_replay(4);
        @(posedge clk);
        i_replay_stall <= 1'b0;
        wait_replay(6'd30, 32'h9000, LSU_FUNC_LW);
        retire_load(6'd30, 1'b0);

        // A flushed miss must not come back when its line arrives
        alloc_load(6'd31, 32'hA000, LSU_FUNC_LW, 1'b1);
        for (int i = 0; i < LQ_DEPTH - 1; i++) begin
            alloc_load(rob_tag_t'(32 + i), addr_t'(32'hA100 + i * 4), LSU_FUNC_LW, 1'b0);
        end
        @(negedge clk);
        check_val("o_full", 1'b1, o_full);
        flush_queue();
        @(negedge clk);
        check_val("o_full", 1'b0, o_full);
        fill_line(32'hA000);
        expect_no_replay(4);

        // Slot 0 waits on its line while both stores retire, slot 1 has already read memory
        alloc_load(6'd40, 32'hB000, LSU_FUNC_LW, 1'b1);
        alloc_load(6'd41, 32'hB010, LSU_FUNC_LHU, 1'b0);
        retire_store(32'hB000, LSU_FUNC_SW);
        retire_store(32'hB00E, LSU_FUNC_SW);
        fill_line(32'hB000);
        wait_replay(6'd40, 32'hB000, LSU_FUNC_LW);
        retire_load(6'd40, 1'b0);
        retire_load(6'd41, ref_overlap(32'hB010, 32'hB000, LSU_FUNC_SW)
                         | ref_overlap(32'hB010, 32'hB00E, LSU_FUNC_SW));

        $display("TESTS PASSED");
        $finish;
    end

endmodule
